// ==== design/exec_pkg.sv ====
package exec_pkg;

    // datapath and tag widths
    localparam int xlen = 32;
    localparam int tag_w = 6;

    // one bit per unresolved branch
    localparam int b_mask_w = 4;

    // shift amount taken from the low bits of operand b
    localparam int shamt_w = $clog2(xlen);

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_slt = 3'd7
    } alu_op_t;

    // single-cycle alu result
    function automatic logic [xlen-1:0] alu_compute(
        input alu_op_t         op,
        input logic [xlen-1:0] opa,
        input logic [xlen-1:0] opb
    );
        logic [xlen-1:0] result;
        logic [shamt_w-1:0] shamt;

        shamt = opb[shamt_w-1:0];
        case (op)
            op_add: result = opa + opb;
            op_sub: result = opa - opb;
            op_and: result = opa & opb;
            op_or:  result = opa | opb;
            op_xor: result = opa ^ opb;
            op_sll: result = opa << shamt;
            op_srl: result = opa >> shamt;
            // signed compare, result is 0 or 1
            op_slt: result = {{(xlen-1){1'b0}}, ($signed(opa) < $signed(opb))};
            default: result = '0;
        endcase
        return result;
    endfunction

endpackage

// ==== design/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit #(
    parameter int num_alu = 2
) (
    input  logic                                          clock,
    input  logic                                          reset,

    // issue side, one element per alu
    input  logic [num_alu-1:0]                            alu_issue_valid,
    input  exec_pkg::alu_op_t [num_alu-1:0]               alu_issue_op,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]        alu_issue_opa,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]        alu_issue_opb,
    input  logic [num_alu-1:0][exec_pkg::tag_w-1:0]       alu_issue_tag,

    // results toward the completion selector
    output logic [num_alu-1:0]                            alu_valid,
    output logic [num_alu-1:0][exec_pkg::tag_w-1:0]       alu_tag,
    output logic [num_alu-1:0][exec_pkg::xlen-1:0]        alu_value
);

    logic [num_alu-1:0]                      issued_valid;
    exec_pkg::alu_op_t [num_alu-1:0]         issued_op;
    logic [num_alu-1:0][exec_pkg::xlen-1:0]  issued_opa;
    logic [num_alu-1:0][exec_pkg::xlen-1:0]  issued_opb;
    logic [num_alu-1:0][exec_pkg::tag_w-1:0] issued_tag;

    // issue valids, cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            issued_valid <= '0;
        end else begin
            issued_valid <= alu_issue_valid;
        end
    end

    // operands and tags captured every cycle
    always_ff @(posedge clock) begin
        issued_op  <= alu_issue_op;
        issued_opa <= alu_issue_opa;
        issued_opb <= alu_issue_opb;
        issued_tag <= alu_issue_tag;
    end

    // results are combinational off the issue registers;
    // an ungranted result is simply overwritten next edge
    always_comb begin
        for (int i = 0; i < num_alu; i++) begin
            alu_valid[i] = issued_valid[i];
            alu_tag[i]   = issued_tag[i];
            alu_value[i] = exec_pkg::alu_compute(issued_op[i], issued_opa[i], issued_opb[i]);
        end
    end

endmodule

// ==== design/mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit #(
    parameter int mult_stages = 3
) (
    input  logic                          clock,
    input  logic                          reset,

    // issue side is accepted only while mult_free is high
    input  logic                          mult_issue_valid,
    input  logic [exec_pkg::xlen-1:0]     mult_issue_opa,
    input  logic [exec_pkg::xlen-1:0]     mult_issue_opb,
    input  logic [exec_pkg::tag_w-1:0]    mult_issue_tag,
    input  logic [exec_pkg::b_mask_w-1:0] mult_issue_mask,

    // branch resolution
    input  logic [exec_pkg::b_mask_w-1:0] b_mm_resolve,
    input  logic                          b_mm_mispred,

    // last stage consumed by the selector this cycle
    input  logic                          mult_taken,

    output logic                          mult_free,
    output logic                          mult_valid,
    output logic [exec_pkg::tag_w-1:0]    mult_tag,
    output logic [exec_pkg::xlen-1:0]     mult_value
);

    localparam int last = mult_stages - 1;

    // pipeline registers with the fresh product in stage 0
    logic [mult_stages-1:0]                         stage_valid;
    logic [mult_stages-1:0][exec_pkg::tag_w-1:0]    stage_tag;
    logic [mult_stages-1:0][exec_pkg::b_mask_w-1:0] stage_mask;
    logic [mult_stages-1:0][exec_pkg::xlen-1:0]     stage_prod;

    // what each stage would load before squash and mask clear
    logic [mult_stages-1:0]                         src_valid;
    logic [mult_stages-1:0][exec_pkg::tag_w-1:0]    src_tag;
    logic [mult_stages-1:0][exec_pkg::b_mask_w-1:0] src_mask;
    logic [mult_stages-1:0][exec_pkg::xlen-1:0]     src_prod;

    logic                      stall;
    logic                      accept;
    logic [exec_pkg::xlen-1:0] product;

    // untaken result at the end freezes the whole pipe
    assign stall     = stage_valid[last] & ~mult_taken;
    assign mult_free = ~stall;
    assign accept    = mult_issue_valid & mult_free;

    // low half of the unsigned product
    assign product = mult_issue_opa * mult_issue_opb;

    always_comb begin
        if (stall) begin
            src_valid = stage_valid;
            src_tag   = stage_tag;
            src_mask  = stage_mask;
            src_prod  = stage_prod;
        end else begin
            src_valid[0] = accept;
            src_tag[0]   = mult_issue_tag;
            src_mask[0]  = mult_issue_mask;
            src_prod[0]  = product;
            for (int k = 1; k < mult_stages; k++) begin
                src_valid[k] = stage_valid[k-1];
                src_tag[k]   = stage_tag[k-1];
                src_mask[k]  = stage_mask[k-1];
                src_prod[k]  = stage_prod[k-1];
            end
        end
    end

    // squash on mispredict overlap, otherwise drop the resolved bit
    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            for (int k = 0; k < mult_stages; k++) begin
                stage_valid[k] <= src_valid[k]
                    & ~(b_mm_mispred & (|(src_mask[k] & b_mm_resolve)));
            end
        end
    end

    // payload follows the valid
    always_ff @(posedge clock) begin
        for (int k = 0; k < mult_stages; k++) begin
            stage_tag[k]  <= src_tag[k];
            stage_mask[k] <= src_mask[k] & ~b_mm_resolve;
            stage_prod[k] <= src_prod[k];
        end
    end

    assign mult_valid = stage_valid[last];
    assign mult_tag   = stage_tag[last];
    assign mult_value = stage_prod[last];

endmodule

// ==== design/complete_select.sv ====
`timescale 1ns/1ps

module complete_select #(
    parameter int num_alu   = 2,
    parameter int num_lanes = 2
) (
    input  logic                                                clock,
    input  logic                                                reset,

    // unit results, index 0 is the multiplier
    input  logic [num_alu:0]                                    fu_valid,
    input  logic [num_alu:0][exec_pkg::tag_w-1:0]               fu_tag,
    input  logic [num_alu:0][exec_pkg::xlen-1:0]                fu_value,

    // one unit-select word per lane
    input  logic [num_lanes-1:0][num_alu:0]                     complete_gnt,

    output logic [num_lanes-1:0]                                cdb_valid,
    output logic [num_lanes-1:0][exec_pkg::tag_w-1:0]           cdb_tag,
    output logic [num_lanes-1:0][exec_pkg::xlen-1:0]            cdb_value,
    output logic                                                mult_taken
);

    localparam int num_fu = num_alu + 1;

    logic [num_lanes-1:0]                      next_valid;
    logic [num_lanes-1:0][exec_pkg::tag_w-1:0] next_tag;
    logic [num_lanes-1:0][exec_pkg::xlen-1:0]  next_value;

    // lane mux, empty lane or invalid unit leaves zeros
    always_comb begin
        next_valid = '0;
        next_tag   = '0;
        next_value = '0;
        mult_taken = 1'b0;
        for (int l = 0; l < num_lanes; l++) begin
            for (int u = 0; u < num_fu; u++) begin
                if (complete_gnt[l][u] && fu_valid[u]) begin
                    next_valid[l] = 1'b1;
                    next_tag[l]   = fu_tag[u];
                    next_value[l] = fu_value[u];
                end
            end
            // multiplier leaves its last stage only when actually moved
            if (complete_gnt[l][0] && fu_valid[0]) begin
                mult_taken = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= '0;
        end else begin
            cdb_valid <= next_valid;
        end
    end

    always_ff @(posedge clock) begin
        cdb_tag   <= next_tag;
        cdb_value <= next_value;
    end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage #(
    parameter int num_alu     = 2,
    parameter int num_lanes   = 2,
    parameter int mult_stages = 3
) (
    input  logic                                       clock,
    input  logic                                       reset,

    // alu issue
    input  logic [num_alu-1:0]                         alu_issue_valid,
    input  exec_pkg::alu_op_t [num_alu-1:0]            alu_issue_op,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]     alu_issue_opa,
    input  logic [num_alu-1:0][exec_pkg::xlen-1:0]     alu_issue_opb,
    input  logic [num_alu-1:0][exec_pkg::tag_w-1:0]    alu_issue_tag,

    // multiplier issue
    input  logic                                       mult_issue_valid,
    input  logic [exec_pkg::xlen-1:0]                  mult_issue_opa,
    input  logic [exec_pkg::xlen-1:0]                  mult_issue_opb,
    input  logic [exec_pkg::tag_w-1:0]                 mult_issue_tag,
    input  logic [exec_pkg::b_mask_w-1:0]              mult_issue_mask,

    // branch resolution
    input  logic [exec_pkg::b_mask_w-1:0]              b_mm_resolve,
    input  logic                                       b_mm_mispred,

    // completion grants, unit 0 is the multiplier
    input  logic [num_lanes-1:0][num_alu:0]            complete_gnt,

    output logic                                       mult_free,
    output logic [num_lanes-1:0]                       cdb_valid,
    output logic [num_lanes-1:0][exec_pkg::tag_w-1:0]  cdb_tag,
    output logic [num_lanes-1:0][exec_pkg::xlen-1:0]   cdb_value
);

    localparam int num_fu = num_alu + 1;

    logic [num_alu-1:0]                      alu_valid;
    logic [num_alu-1:0][exec_pkg::tag_w-1:0] alu_tag;
    logic [num_alu-1:0][exec_pkg::xlen-1:0]  alu_value;

    logic                         mult_valid;
    logic [exec_pkg::tag_w-1:0]   mult_tag;
    logic [exec_pkg::xlen-1:0]    mult_value;
    logic                         mult_taken;

    logic [num_fu-1:0]                      fu_valid;
    logic [num_fu-1:0][exec_pkg::tag_w-1:0] fu_tag;
    logic [num_fu-1:0][exec_pkg::xlen-1:0]  fu_value;

    // multiplier sits at the lowest unit index
    assign fu_valid = {alu_valid, mult_valid};
    assign fu_tag   = {alu_tag, mult_tag};
    assign fu_value = {alu_value, mult_value};

    alu_unit #(
        .num_alu(num_alu)
    ) alu_unit_i (
        .clock(clock),
        .reset(reset),
        .alu_issue_valid(alu_issue_valid),
        .alu_issue_op(alu_issue_op),
        .alu_issue_opa(alu_issue_opa),
        .alu_issue_opb(alu_issue_opb),
        .alu_issue_tag(alu_issue_tag),
        .alu_valid(alu_valid),
        .alu_tag(alu_tag),
        .alu_value(alu_value)
    );

    mult_unit #(
        .mult_stages(mult_stages)
    ) mult_unit_i (
        .clock(clock),
        .reset(reset),
        .mult_issue_valid(mult_issue_valid),
        .mult_issue_opa(mult_issue_opa),
        .mult_issue_opb(mult_issue_opb),
        .mult_issue_tag(mult_issue_tag),
        .mult_issue_mask(mult_issue_mask),
        .b_mm_resolve(b_mm_resolve),
        .b_mm_mispred(b_mm_mispred),
        .mult_taken(mult_taken),
        .mult_free(mult_free),
        .mult_valid(mult_valid),
        .mult_tag(mult_tag),
        .mult_value(mult_value)
    );

    complete_select #(
        .num_alu(num_alu),
        .num_lanes(num_lanes)
    ) complete_select_i (
        .clock(clock),
        .reset(reset),
        .fu_valid(fu_valid),
        .fu_tag(fu_tag),
        .fu_value(fu_value),
        .complete_gnt(complete_gnt),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_value(cdb_value),
        .mult_taken(mult_taken)
    );

endmodule

// ==== dv/execute_stage_tb.sv ====
`timescale 1ns/1ps

module execute_stage_tb;

    localparam int num_alu     = 2;
    localparam int num_lanes   = 2;
    localparam int mult_stages = 3;
    localparam int num_fields  = 26;

    logic                                      clock;
    logic                                      reset;
    logic [num_alu-1:0]                        alu_issue_valid;
    exec_pkg::alu_op_t [num_alu-1:0]           alu_issue_op;
    logic [num_alu-1:0][exec_pkg::xlen-1:0]    alu_issue_opa;
    logic [num_alu-1:0][exec_pkg::xlen-1:0]    alu_issue_opb;
    logic [num_alu-1:0][exec_pkg::tag_w-1:0]   alu_issue_tag;
    logic                                      mult_issue_valid;
    logic [exec_pkg::xlen-1:0]                 mult_issue_opa;
    logic [exec_pkg::xlen-1:0]                 mult_issue_opb;
    logic [exec_pkg::tag_w-1:0]                mult_issue_tag;
    logic [exec_pkg::b_mask_w-1:0]             mult_issue_mask;
    logic [exec_pkg::b_mask_w-1:0]             b_mm_resolve;
    logic                                      b_mm_mispred;
    logic [num_lanes-1:0][num_alu:0]           complete_gnt;
    logic                                      mult_free;
    logic [num_lanes-1:0]                      cdb_valid;
    logic [num_lanes-1:0][exec_pkg::tag_w-1:0] cdb_tag;
    logic [num_lanes-1:0][exec_pkg::xlen-1:0]  cdb_value;

    string       data_lines[$];
    int          cycle_count;
    int          cycle_limit;
    int          error_count;

    // expected cdb per lane from the previous data line
    logic [num_lanes-1:0]       exp_valid;
    logic [num_lanes-1:0][31:0] exp_tag;
    logic [num_lanes-1:0][31:0] exp_value;

    // alu results the model expects to be visible this cycle
    logic [num_alu-1:0]         model_valid;
    logic [num_alu-1:0][31:0]   model_tag;
    logic [num_alu-1:0][31:0]   model_value;

    execute_stage #(
        .num_alu(num_alu),
        .num_lanes(num_lanes),
        .mult_stages(mult_stages)
    ) execute_stage_i (
        .clock(clock),
        .reset(reset),
        .alu_issue_valid(alu_issue_valid),
        .alu_issue_op(alu_issue_op),
        .alu_issue_opa(alu_issue_opa),
        .alu_issue_opb(alu_issue_opb),
        .alu_issue_tag(alu_issue_tag),
        .mult_issue_valid(mult_issue_valid),
        .mult_issue_opa(mult_issue_opa),
        .mult_issue_opb(mult_issue_opb),
        .mult_issue_tag(mult_issue_tag),
        .mult_issue_mask(mult_issue_mask),
        .b_mm_resolve(b_mm_resolve),
        .b_mm_mispred(b_mm_mispred),
        .complete_gnt(complete_gnt),
        .mult_free(mult_free),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_value(cdb_value)
    );

    always #10 clock = ~clock;

    // run length bounded by the number of data lines
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: simulation ran past %0d cycles", cycle_limit);
            $display("Some tests failed");
            $fatal(1, "stopped on timeout");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic check_cdb();
        for (int l = 0; l < num_lanes; l++) begin
            check_value(32'(cdb_valid[l]), 32'(exp_valid[l]), $sformatf("lane %0d valid", l));
            if (exp_valid[l]) begin
                check_value(32'(cdb_tag[l]), exp_tag[l], $sformatf("lane %0d tag", l));
                check_value(cdb_value[l], exp_value[l], $sformatf("lane %0d value", l));
            end
        end
    endtask

    task automatic read_data_file();
        int    fd;
        string text;

        fd = $fopen("dv/exec_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/exec_testdata.txt");
            $display("Some tests failed");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 1 && text.getc(0) != "#") begin
                data_lines.push_back(text);
            end
        end
        $fclose(fd);
    endtask

    // apply one line and cross-check alu expectations against the model
    task automatic apply_line(input string text, input int line_no);
        logic [31:0] f[num_fields];
        int          count;
        int          unit;

        count = $sscanf(text,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12],
            f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23],
            f[24], f[25]);
        if (count != num_fields) begin
            $display("data line %0d has %0d fields instead of %0d", line_no, count, num_fields);
            $display("Some tests failed");
            $fatal(1, "bad stimulus");
        end
        for (int i = 0; i < num_alu; i++) begin
            alu_issue_valid[i] = f[5*i][0];
            alu_issue_op[i]    = exec_pkg::alu_op_t'(f[5*i+1][2:0]);
            alu_issue_opa[i]   = f[5*i+2];
            alu_issue_opb[i]   = f[5*i+3];
            alu_issue_tag[i]   = f[5*i+4][exec_pkg::tag_w-1:0];
        end
        mult_issue_valid = f[10][0];
        mult_issue_opa   = f[11];
        mult_issue_opb   = f[12];
        mult_issue_tag   = f[13][exec_pkg::tag_w-1:0];
        mult_issue_mask  = f[14][exec_pkg::b_mask_w-1:0];
        b_mm_resolve     = f[15][exec_pkg::b_mask_w-1:0];
        b_mm_mispred     = f[16][0];
        complete_gnt[0]  = f[17][num_alu:0];
        complete_gnt[1]  = f[18][num_alu:0];
        for (int l = 0; l < num_lanes; l++) begin
            exp_valid[l] = f[19+3*l][0];
            exp_tag[l]   = f[20+3*l];
            exp_value[l] = f[21+3*l];
            // a granted alu result must match the file's expectation
            for (unit = 1; unit <= num_alu; unit++) begin
                if (complete_gnt[l][unit] && model_valid[unit-1]) begin
                    check_value(32'(exp_valid[l]), 32'd1,
                                $sformatf("testdata line %0d valid", line_no));
                    check_value(exp_tag[l], model_tag[unit-1],
                                $sformatf("testdata line %0d tag", line_no));
                    check_value(exp_value[l], model_value[unit-1],
                                $sformatf("testdata line %0d value", line_no));
                end
            end
        end
        for (int i = 0; i < num_alu; i++) begin
            model_valid[i] = alu_issue_valid[i];
            model_tag[i]   = 32'(alu_issue_tag[i]);
            model_value[i] = exec_pkg::alu_compute(alu_issue_op[i], alu_issue_opa[i],
                                                   alu_issue_opb[i]);
        end
        #1;
        check_value(32'(mult_free), f[25], $sformatf("mult_free on line %0d", line_no));
    endtask

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        alu_issue_valid  = '0;
        for (int i = 0; i < num_alu; i++) begin
            alu_issue_op[i] = exec_pkg::op_add;
        end
        alu_issue_opa    = '0;
        alu_issue_opb    = '0;
        alu_issue_tag    = '0;
        mult_issue_valid = 1'b0;
        mult_issue_opa   = '0;
        mult_issue_opb   = '0;
        mult_issue_tag   = '0;
        mult_issue_mask  = '0;
        b_mm_resolve     = '0;
        b_mm_mispred     = 1'b0;
        complete_gnt     = '0;
        cycle_count      = 0;
        cycle_limit      = 0;
        error_count      = 0;
        model_valid      = '0;
        model_tag        = '0;
        model_value      = '0;
        exp_valid        = '0;
        exp_tag          = '0;
        exp_value        = '0;

        read_data_file();
        cycle_limit = data_lines.size() + 20;

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // the first pass sees the cdb straight out of reset
        for (int n = 0; n < data_lines.size(); n++) begin
            if (n > 0) begin
                @(negedge clock);
            end
            check_cdb();
            apply_line(data_lines[n], n + 1);
        end
        @(negedge clock);
        check_cdb();

        if (error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== dv/exec_testdata.txt ====
# alu0: v op opa opb tag | alu1: v op opa opb tag | mult: v opa opb tag mask | resolve mispred
# gnt0 gnt1 | lane0: v tag value | lane1: v tag value | mult_free   (all hex, one line per cycle)
1 0 5 3 01 1 1 a 4 02 0 0 0 00 0 0 0 0 0 0 00 0 0 00 0 1
1 2 f0 3c 03 1 3 f0 0f 04 0 0 0 00 0 0 0 2 4 1 01 8 1 02 6 1
1 4 ff 0f 05 1 5 1 4 06 0 0 0 00 0 0 0 4 2 1 04 ff 1 03 30 1
1 6 80 3 07 1 7 ffffffff 1 08 0 0 0 00 0 0 0 2 4 1 05 f0 1 06 10 1
1 0 1 1 09 0 0 0 0 00 0 0 0 00 0 0 0 2 4 1 07 10 1 08 1 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 0 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 2 4 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 1 6 7 10 0 0 0 1 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 1 3 5 11 0 0 0 1 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 1 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 1 0 1 10 2a 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 1 0 1 11 f 0 00 0 1
0 0 0 0 00 0 0 0 0 00 1 ffffffff 2 12 0 0 0 0 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 0 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 0 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 0 0 0 00 0 0 00 0 0
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 0 0 0 00 0 0 00 0 0
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 0 1 0 00 0 1 12 fffffffe 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 0 1 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 1 2 3 13 1 0 0 0 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 1 1 1 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 1 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 1 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 1 4 5 14 2 0 0 1 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 2 0 1 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 2 1 1 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 1 0 1 14 14 0 00 0 1
0 0 0 0 00 0 0 0 0 00 1 9 9 15 0 0 0 0 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 0 0 0 00 0 0 00 0 1
0 0 0 0 00 1 4 aaaa 5555 16 0 0 0 00 0 0 0 0 0 0 00 0 0 00 0 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 4 1 1 16 ffff 1 15 51 1
0 0 0 0 00 0 0 0 0 00 0 0 0 00 0 0 0 0 0 0 00 0 0 00 0 1

// ==== tb.f ====
design/exec_pkg.sv
design/alu_unit.sv
design/mult_unit.sv
design/complete_select.sv
design/execute_stage.sv
dv/execute_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= execute_stage_tb
RTL_TOP   ?= execute_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

RTL_SRCS = design/exec_pkg.sv design/alu_unit.sv design/mult_unit.sv \
           design/complete_select.sv design/execute_stage.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
